//--- common/db_route_pkg.sv
// ==============================
// Widths and counts shared by the lookup routing fabric
// NUM_RESP of 1 still yields a 1-bit responder index
// ==============================
`default_nettype none

package db_route_pkg;

    // ==============================
    // Lookup word widths
    // ==============================

    // Lookup key carried with each request
    localparam int KEY_WID = 8;

    // Lookup result returned with each ack
    localparam int VALUE_WID = 32;

    // ==============================
    // Fabric dimensions
    // ==============================

    // Responders behind the round-robin demux
    localparam int NUM_RESP = 2;

    // Responder index, kept at least one bit wide
    localparam int RESP_SEL_WID = (NUM_RESP > 1) ? $clog2(NUM_RESP) : 1;

    // Requests in flight tracked per routing stage
    localparam int CTXT_DEPTH = 32;

endpackage : db_route_pkg

`default_nettype wire

//--- db_demux/db_rr_demux.sv
// ==============================
// Responders are served in strict turn, one busy responder stalls all
// Responses must come back in global acceptance order
// ==============================
`timescale 1ns/1ps
`default_nettype none

module db_rr_demux (
    input  wire logic                                clk,
    input  wire logic                                i_reset,

    // Upstream requester side
    input  wire logic                                i_req,
    input  wire logic [db_route_pkg::KEY_WID-1:0]    i_key,
    output logic                                     o_rdy,
    output logic                                     o_ack,
    output logic                                     o_error,
    output logic                                     o_valid,
    output logic      [db_route_pkg::VALUE_WID-1:0]  o_value,

    // Responder side
    output logic      [db_route_pkg::NUM_RESP-1:0]   o_resp_req,
    output logic      [db_route_pkg::KEY_WID-1:0]    o_resp_key,
    input  wire logic [db_route_pkg::NUM_RESP-1:0]   i_resp_rdy,
    input  wire logic [db_route_pkg::NUM_RESP-1:0]   i_resp_ack,
    input  wire logic [db_route_pkg::NUM_RESP-1:0]   i_resp_error,
    input  wire logic [db_route_pkg::NUM_RESP-1:0]   i_resp_valid,
    input  wire logic [db_route_pkg::VALUE_WID-1:0]  i_resp_value [db_route_pkg::NUM_RESP]
);

    import db_route_pkg::*;

    logic [RESP_SEL_WID-1:0] turn;
    logic [RESP_SEL_WID-1:0] head_sel;
    logic                    ctxt_full;
    logic                    ctxt_empty;
    logic                    accept;

    // ==============================
    // Request dealing
    // ==============================

    // Only the responder whose turn it is sees the request
    always_comb begin
        o_resp_req = '0;
        for (int i = 0; i < NUM_RESP; i++) begin
            if (turn == RESP_SEL_WID'(i)) begin
                o_resp_req[i] = i_req && !ctxt_full;
            end
        end
    end

    assign o_resp_key = i_key;
    assign o_rdy      = i_resp_rdy[turn] && !ctxt_full;
    assign accept     = i_req && o_rdy;

    // Turn counter, holds while the current responder stalls
    always_ff @(posedge clk) begin
        if (i_reset) begin
            turn <= '0;
        end else if (accept) begin
            if (turn == RESP_SEL_WID'(NUM_RESP - 1)) begin
                turn <= '0;
            end else begin
                turn <= turn + 1'b1;
            end
        end
    end

    // Target responder of each accepted request
    ctxt_fifo #(
        .WIDTH     ( RESP_SEL_WID ),
        .DEPTH     ( CTXT_DEPTH )
    ) ctxt_fifo_inst (
        .clk       ( clk ),
        .i_reset   ( i_reset ),
        .i_wr      ( accept ),
        .i_wr_data ( turn ),
        .i_rd      ( o_ack ),
        .o_rd_data ( head_sel ),
        .o_full    ( ctxt_full ),
        .o_empty   ( ctxt_empty )
    );

    // ==============================
    // Response collection
    // ==============================

    // Listen only to the responder owning the oldest request
    assign o_ack   = !ctxt_empty && i_resp_ack[head_sel];
    assign o_error = i_resp_error[head_sel];
    assign o_valid = i_resp_valid[head_sel];
    assign o_value = i_resp_value[head_sel];

endmodule : db_rr_demux

`default_nettype wire

//--- db_mux/db_prio_mux.sv
// ==============================
// Strict priority, so a busy hi side can starve the lo side
// Downstream must answer in acceptance order
// ==============================
`timescale 1ns/1ps
`default_nettype none

module db_prio_mux (
    input  wire logic                           clk,
    input  wire logic                           i_reset,

    // High-priority requester
    input  wire logic                           i_hi_req,
    input  wire logic [db_route_pkg::KEY_WID-1:0]   i_hi_key,
    output logic                                o_hi_rdy,
    output logic                                o_hi_ack,
    output logic                                o_hi_error,
    output logic                                o_hi_valid,
    output logic      [db_route_pkg::VALUE_WID-1:0] o_hi_value,

    // Low-priority requester
    input  wire logic                           i_lo_req,
    input  wire logic [db_route_pkg::KEY_WID-1:0]   i_lo_key,
    output logic                                o_lo_rdy,
    output logic                                o_lo_ack,
    output logic                                o_lo_error,
    output logic                                o_lo_valid,
    output logic      [db_route_pkg::VALUE_WID-1:0] o_lo_value,

    // Merged downstream path
    output logic                                o_req,
    output logic      [db_route_pkg::KEY_WID-1:0]   o_key,
    input  wire logic                           i_rdy,
    input  wire logic                           i_ack,
    input  wire logic                           i_error,
    input  wire logic                           i_valid,
    input  wire logic [db_route_pkg::VALUE_WID-1:0] i_value
);

    import db_route_pkg::*;

    logic sel_lo;
    logic ctxt_full;
    logic ctxt_empty;
    logic ctxt_head_lo;
    logic accept;
    logic ack_ok;

    // ==============================
    // Request side
    // ==============================

    // Lo side wins only when hi side is idle
    assign sel_lo = i_lo_req && !i_hi_req;

    // Hold the request back while no context slot is free
    assign o_req = (sel_lo ? i_lo_req : i_hi_req) && !ctxt_full;
    assign o_key = sel_lo ? i_lo_key : i_hi_key;

    assign o_hi_rdy = !sel_lo && i_rdy && !ctxt_full;
    assign o_lo_rdy = sel_lo && i_rdy && !ctxt_full;

    assign accept = o_req && i_rdy;

    // Source side of each accepted request, oldest at head
    ctxt_fifo #(
        .WIDTH     ( 1 ),
        .DEPTH     ( CTXT_DEPTH )
    ) ctxt_fifo_inst (
        .clk       ( clk ),
        .i_reset   ( i_reset ),
        .i_wr      ( accept ),
        .i_wr_data ( sel_lo ),
        .i_rd      ( i_ack ),
        .o_rd_data ( ctxt_head_lo ),
        .o_full    ( ctxt_full ),
        .o_empty   ( ctxt_empty )
    );

    // ==============================
    // Response side
    // ==============================

    // A stray ack with nothing in flight goes nowhere
    assign ack_ok = i_ack && !ctxt_empty;

    assign o_hi_ack   = ack_ok && !ctxt_head_lo;
    assign o_hi_error = ack_ok && !ctxt_head_lo && i_error;
    assign o_lo_ack   = ack_ok && ctxt_head_lo;
    assign o_lo_error = ack_ok && ctxt_head_lo && i_error;

    // Result payload is shared, the ack qualifies it
    assign o_hi_valid = i_valid;
    assign o_hi_value = i_value;
    assign o_lo_valid = i_valid;
    assign o_lo_value = i_value;

endmodule : db_prio_mux

`default_nettype wire

//--- dv/db_route_tb.sv
// ==============================
// Responder models answer in global acceptance order, at most 8 in flight
// ==============================
`timescale 1ns/1ps
`default_nettype none

module db_route_tb;

    import db_route_pkg::*;

    localparam int MAX_FLIGHT  = 8;
    localparam int DRAIN_LIMIT = 5000;

    logic                 clk;
    logic                 i_reset;
    logic                 i_hi_req;
    logic [KEY_WID-1:0]   i_hi_key;
    logic                 o_hi_rdy;
    logic                 o_hi_ack;
    logic                 o_hi_error;
    logic                 o_hi_valid;
    logic [VALUE_WID-1:0] o_hi_value;
    logic                 i_lo_req;
    logic [KEY_WID-1:0]   i_lo_key;
    logic                 o_lo_rdy;
    logic                 o_lo_ack;
    logic                 o_lo_error;
    logic                 o_lo_valid;
    logic [VALUE_WID-1:0] o_lo_value;
    logic [NUM_RESP-1:0]  o_resp_req;
    logic [KEY_WID-1:0]   o_resp_key;
    logic [NUM_RESP-1:0]  i_resp_rdy;
    logic [NUM_RESP-1:0]  i_resp_ack;
    logic [NUM_RESP-1:0]  i_resp_error;
    logic [NUM_RESP-1:0]  i_resp_valid;
    logic [VALUE_WID-1:0] i_resp_value [NUM_RESP];

    // Model state
    logic [31:0]        rng_state;
    int                 error_count;
    int                 test_count;
    int                 failed_tests;
    int                 accept_cnt;
    int                 head_wait;
    int                 hi_left;
    int                 lo_left;
    int                 hi_gap;
    int                 lo_gap;
    logic               hi_busy;
    logic               lo_busy;
    int                 hi_acks;
    int                 lo_acks;
    int                 hi_accepts;
    int                 lo_accepts;
    logic [KEY_WID-1:0] glob_key [$];
    int                 glob_resp [$];
    logic               glob_lo [$];

    db_route_top db_route_top_inst (
        .clk          ( clk ),
        .i_reset      ( i_reset ),
        .i_hi_req     ( i_hi_req ),
        .i_hi_key     ( i_hi_key ),
        .o_hi_rdy     ( o_hi_rdy ),
        .o_hi_ack     ( o_hi_ack ),
        .o_hi_error   ( o_hi_error ),
        .o_hi_valid   ( o_hi_valid ),
        .o_hi_value   ( o_hi_value ),
        .i_lo_req     ( i_lo_req ),
        .i_lo_key     ( i_lo_key ),
        .o_lo_rdy     ( o_lo_rdy ),
        .o_lo_ack     ( o_lo_ack ),
        .o_lo_error   ( o_lo_error ),
        .o_lo_valid   ( o_lo_valid ),
        .o_lo_value   ( o_lo_value ),
        .o_resp_req   ( o_resp_req ),
        .o_resp_key   ( o_resp_key ),
        .i_resp_rdy   ( i_resp_rdy ),
        .i_resp_ack   ( i_resp_ack ),
        .i_resp_error ( i_resp_error ),
        .i_resp_valid ( i_resp_valid ),
        .i_resp_value ( i_resp_value )
    );

    always #2 clk = ~clk;

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Lookup result for a key served by responder idx
    function automatic logic [31:0] lookup_value(input logic [KEY_WID-1:0] key, input int idx);
        return 32'(key) * 32'h9e37_79b9 + 32'(idx);
    endfunction

    // All-ones key shows up often enough to exercise the error flag
    function automatic logic [KEY_WID-1:0] pick_key();
        logic [31:0] r;
        r = next_rand();
        if (r[2:0] == 3'd0) begin
            return 8'hff;
        end
        return r[15:8];
    endfunction

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Fail at %0t ns: %s got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // One clock of stimulus and checking, inputs change on the falling edge
    task automatic step_cycle(input int rdy_pct, input int max_delay);
        int                 r_idx;
        int                 turn_idx;
        logic               ack_drv;
        logic               any_req;
        logic               hi_acc;
        logic               lo_acc;
        logic               side_lo;
        logic [KEY_WID-1:0] key;
        logic [31:0]        rnd;
        @(negedge clk);
        ack_drv = 1'b0;
        for (int i = 0; i < NUM_RESP; i++) begin
            rnd = next_rand();
            i_resp_ack[i]   = 1'b0;
            i_resp_valid[i] = rnd[0];
            i_resp_error[i] = rnd[1];
            i_resp_value[i] = next_rand();
            i_resp_rdy[i]   = (next_rand() % 100 < rdy_pct) && (glob_key.size() < MAX_FLIGHT);
        end
        // Oldest request is answered after its random delay
        if (glob_key.size() > 0) begin
            if (head_wait > 0) begin
                head_wait--;
            end else begin
                ack_drv = 1'b1;
                r_idx = glob_resp[0];
                i_resp_ack[r_idx]   = 1'b1;
                i_resp_value[r_idx] = lookup_value(glob_key[0], r_idx);
                i_resp_valid[r_idx] = glob_key[0][0];
                i_resp_error[r_idx] = (glob_key[0] == 8'hff);
            end
        end
        // Requester drivers hold req and key until accepted
        if (!hi_busy && hi_left > 0 && hi_gap == 0) begin
            hi_busy = 1'b1;
            i_hi_key = pick_key();
        end else if (!hi_busy && hi_gap > 0) begin
            hi_gap--;
        end
        if (!lo_busy && lo_left > 0 && lo_gap == 0) begin
            lo_busy = 1'b1;
            i_lo_key = pick_key();
        end else if (!lo_busy && lo_gap > 0) begin
            lo_gap--;
        end
        i_hi_req = hi_busy;
        i_lo_req = lo_busy;
        #1;
        if (ack_drv) begin
            side_lo = glob_lo[0];
            key = glob_key[0];
            check_equal("hi ack", 32'(o_hi_ack), 32'(!side_lo));
            check_equal("lo ack", 32'(o_lo_ack), 32'(side_lo));
            check_equal("value", side_lo ? o_lo_value : o_hi_value, lookup_value(key, glob_resp[0]));
            check_equal("valid", 32'(side_lo ? o_lo_valid : o_hi_valid), 32'(key[0]));
            check_equal("error", 32'(side_lo ? o_lo_error : o_hi_error), 32'(key == 8'hff));
            void'(glob_key.pop_front());
            void'(glob_resp.pop_front());
            void'(glob_lo.pop_front());
            head_wait = int'(next_rand() % 32'(max_delay + 1));
        end else begin
            check_equal("idle hi ack", 32'(o_hi_ack), 32'd0);
            check_equal("idle lo ack", 32'(o_lo_ack), 32'd0);
        end
        // Acks seen at the requester ports
        if (o_hi_ack) begin
            hi_acks++;
        end
        if (o_lo_ack) begin
            lo_acks++;
        end
        turn_idx = accept_cnt % NUM_RESP;
        any_req = i_hi_req || i_lo_req;
        if (i_hi_req && i_lo_req) begin
            check_equal("lo rdy under contention", 32'(o_lo_rdy), 32'd0);
        end
        check_equal("resp req", 32'(o_resp_req), any_req ? 32'(1 << turn_idx) : 32'd0);
        if (any_req) begin
            check_equal("resp key", 32'(o_resp_key), 32'(i_hi_req ? i_hi_key : i_lo_key));
        end
        hi_acc = i_hi_req && o_hi_rdy;
        lo_acc = i_lo_req && o_lo_rdy;
        check_equal("accept", 32'(hi_acc || lo_acc), 32'(any_req && i_resp_rdy[turn_idx]));
        check_equal("single grant", 32'(hi_acc && lo_acc), 32'd0);
        if (hi_acc || lo_acc) begin
            glob_key.push_back(hi_acc ? i_hi_key : i_lo_key);
            glob_resp.push_back(turn_idx);
            glob_lo.push_back(!hi_acc);
            if (glob_key.size() == 1) begin
                head_wait = int'(next_rand() % 32'(max_delay + 1));
            end
            accept_cnt++;
            if (hi_acc) begin
                hi_busy = 1'b0;
                hi_left--;
                hi_accepts++;
                hi_gap = int'(next_rand() % 4);
            end else begin
                lo_busy = 1'b0;
                lo_left--;
                lo_accepts++;
                lo_gap = int'(next_rand() % 4);
            end
        end
    endtask

    // Runs traffic until every request is answered or the drain limit hits
    task automatic run_traffic(input string name, input int n_hi, input int n_lo,
                               input int rdy_pct, input int max_delay, input int min_cycles);
        int cycles;
        int errors_before;
        errors_before = error_count;
        hi_left = n_hi;
        lo_left = n_lo;
        hi_acks = 0;
        lo_acks = 0;
        hi_accepts = 0;
        lo_accepts = 0;
        cycles = 0;
        while ((cycles < min_cycles || hi_left > 0 || lo_left > 0 || glob_key.size() > 0)
               && cycles < DRAIN_LIMIT) begin
            step_cycle(rdy_pct, max_delay);
            cycles++;
        end
        if (cycles >= DRAIN_LIMIT) begin
            error_count++;
            $display("Timeout in test %s: requests still outstanding after %0d cycles",
                     name, cycles);
        end
        check_equal("hi ack count", 32'(hi_acks), 32'(hi_accepts));
        check_equal("lo ack count", 32'(lo_acks), 32'(lo_accepts));
        test_count++;
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("Test %-10s %s: %0d hi and %0d lo answered, %0d errors", name,
                 (error_count == errors_before) ? "ok" : "FAILED",
                 hi_acks, lo_acks, error_count - errors_before);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        rng_state = 32'hd953_4bf4;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        accept_cnt = 0;
        head_wait = 0;
        hi_busy = 1'b0;
        lo_busy = 1'b0;
        hi_gap = 0;
        lo_gap = 0;
        clk = 1'b0;
        i_reset = 1'b1;
        i_hi_req = 1'b0;
        i_hi_key = '0;
        i_lo_req = 1'b0;
        i_lo_key = '0;
        i_resp_rdy = '0;
        i_resp_ack = '0;
        i_resp_error = '0;
        i_resp_valid = '0;
        for (int i = 0; i < NUM_RESP; i++) begin
            i_resp_value[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;

        run_traffic("idle", 0, 0, 50, 0, 20);
        run_traffic("hi_only", 60, 0, 70, 3, 0);
        run_traffic("both", 80, 80, 70, 3, 0);
        run_traffic("stall", 100, 100, 30, 12, 0);

        $display("Totals: %0d tests, %0d failed, %0d check errors",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : db_route_tb

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the routing fabric testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
SIM_BIN=db_route_sim
LOG_FILE=sim.log

rm -rf "${BUILD_DIR}"

verilator --binary --timing \
    --top-module db_route_tb \
    -f vlog.f \
    -Mdir "${BUILD_DIR}" \
    -o "${SIM_BIN}"

"./${BUILD_DIR}/${SIM_BIN}" | tee "${LOG_FILE}"

if grep -q "Test failures found" "${LOG_FILE}"; then
    echo "Simulation reported failing checks, see ${LOG_FILE}"
    exit 1
fi

echo "Simulation finished without failing checks"
exit 0

//--- src/ctxt_fifo.sv
// ==============================
// Writes to a full FIFO and reads of an empty FIFO are dropped
// Read data is the head entry, valid while o_empty is low
// ==============================
`timescale 1ns/1ps
`default_nettype none

module ctxt_fifo #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 32
) (
    input  wire logic             clk,
    input  wire logic             i_reset,
    input  wire logic             i_wr,
    input  wire logic [WIDTH-1:0] i_wr_data,
    input  wire logic             i_rd,
    output logic      [WIDTH-1:0] o_rd_data,
    output logic                  o_full,
    output logic                  o_empty
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;
    logic               wr_en;
    logic               rd_en;

    assign o_full  = (count == CNT_WID'(DEPTH));
    assign o_empty = (count == '0);

    assign wr_en = i_wr && !o_full;
    assign rd_en = i_rd && !o_empty;

    // Storage array
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    assign o_rd_data = mem[rd_ptr];

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy, push and pop together leave it unchanged
    always_ff @(posedge clk) begin
        if (i_reset) begin
            count <= '0;
        end else if (wr_en && !rd_en) begin
            count <= count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count <= count - 1'b1;
        end
    end

endmodule : ctxt_fifo

`default_nettype wire

//--- src/db_route_top.sv
// ==============================
// Read path only, hi/lo requesters fan out to NUM_RESP responders
// ==============================
`timescale 1ns/1ps
`default_nettype none

module db_route_top (
    input  wire logic                                clk,
    input  wire logic                                i_reset,

    // High-priority requester
    input  wire logic                                i_hi_req,
    input  wire logic [db_route_pkg::KEY_WID-1:0]    i_hi_key,
    output logic                                     o_hi_rdy,
    output logic                                     o_hi_ack,
    output logic                                     o_hi_error,
    output logic                                     o_hi_valid,
    output logic      [db_route_pkg::VALUE_WID-1:0]  o_hi_value,

    // Low-priority requester
    input  wire logic                                i_lo_req,
    input  wire logic [db_route_pkg::KEY_WID-1:0]    i_lo_key,
    output logic                                     o_lo_rdy,
    output logic                                     o_lo_ack,
    output logic                                     o_lo_error,
    output logic                                     o_lo_valid,
    output logic      [db_route_pkg::VALUE_WID-1:0]  o_lo_value,

    // Lookup responders
    output logic      [db_route_pkg::NUM_RESP-1:0]   o_resp_req,
    output logic      [db_route_pkg::KEY_WID-1:0]    o_resp_key,
    input  wire logic [db_route_pkg::NUM_RESP-1:0]   i_resp_rdy,
    input  wire logic [db_route_pkg::NUM_RESP-1:0]   i_resp_ack,
    input  wire logic [db_route_pkg::NUM_RESP-1:0]   i_resp_error,
    input  wire logic [db_route_pkg::NUM_RESP-1:0]   i_resp_valid,
    input  wire logic [db_route_pkg::VALUE_WID-1:0]  i_resp_value [db_route_pkg::NUM_RESP]
);

    import db_route_pkg::*;

    // Merged stream between the two stages
    logic                 mrg_req;
    logic [KEY_WID-1:0]   mrg_key;
    logic                 mrg_rdy;
    logic                 mrg_ack;
    logic                 mrg_error;
    logic                 mrg_valid;
    logic [VALUE_WID-1:0] mrg_value;

    db_prio_mux db_prio_mux_inst (
        .clk        ( clk ),
        .i_reset    ( i_reset ),
        .i_hi_req   ( i_hi_req ),
        .i_hi_key   ( i_hi_key ),
        .o_hi_rdy   ( o_hi_rdy ),
        .o_hi_ack   ( o_hi_ack ),
        .o_hi_error ( o_hi_error ),
        .o_hi_valid ( o_hi_valid ),
        .o_hi_value ( o_hi_value ),
        .i_lo_req   ( i_lo_req ),
        .i_lo_key   ( i_lo_key ),
        .o_lo_rdy   ( o_lo_rdy ),
        .o_lo_ack   ( o_lo_ack ),
        .o_lo_error ( o_lo_error ),
        .o_lo_valid ( o_lo_valid ),
        .o_lo_value ( o_lo_value ),
        .o_req      ( mrg_req ),
        .o_key      ( mrg_key ),
        .i_rdy      ( mrg_rdy ),
        .i_ack      ( mrg_ack ),
        .i_error    ( mrg_error ),
        .i_valid    ( mrg_valid ),
        .i_value    ( mrg_value )
    );

    db_rr_demux db_rr_demux_inst (
        .clk          ( clk ),
        .i_reset      ( i_reset ),
        .i_req        ( mrg_req ),
        .i_key        ( mrg_key ),
        .o_rdy        ( mrg_rdy ),
        .o_ack        ( mrg_ack ),
        .o_error      ( mrg_error ),
        .o_valid      ( mrg_valid ),
        .o_value      ( mrg_value ),
        .o_resp_req   ( o_resp_req ),
        .o_resp_key   ( o_resp_key ),
        .i_resp_rdy   ( i_resp_rdy ),
        .i_resp_ack   ( i_resp_ack ),
        .i_resp_error ( i_resp_error ),
        .i_resp_valid ( i_resp_valid ),
        .i_resp_value ( i_resp_value )
    );

endmodule : db_route_top

`default_nettype wire

//--- vlog.f
common/db_route_pkg.sv
src/ctxt_fifo.sv
db_mux/db_prio_mux.sv
db_demux/db_rr_demux.sv
src/db_route_top.sv
dv/db_route_tb.sv
